// File: tb.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/reorder_buffer.sv
rtl/free_list.sv
rtl/rename_map.sv
rtl/rename_retire_top.sv
tb/tb_rename_retire.sv

// File: tb/tb_rename_retire.sv
// self-checking testbench; stimulus is seeded xorshift, so each run repeats the same traffic
`include "rob_params.svh"

module tb_rename_retire import rob_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        pc_t      pc;
        areg_t    areg;
        fu_e      fu;
        preg_t    preg;
        preg_t    opreg;
        rob_idx_t idx;
        bit       sent;
        bit       done;
        bit       exc;
        logic [4:0] cause;
    } rec_t;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    logic [`DISPATCH_WIDTH-1:0]      dispatch_valid_i = '0;
    dispatch_t [`DISPATCH_WIDTH-1:0] dispatch_i = '0;
    logic [`WB_WIDTH-1:0]            wb_valid_i = '0;
    wb_t [`WB_WIDTH-1:0]             wb_i = '0;
    logic                            dispatch_ready_o;
    rob_idx_t [`DISPATCH_WIDTH-1:0]  dispatch_index_o;
    preg_t [`DISPATCH_WIDTH-1:0]     dispatch_preg_o;
    preg_t [`DISPATCH_WIDTH-1:0]     dispatch_opreg_o;
    logic [`COMMIT_WIDTH-1:0]        commit_valid_o;
    commit_t [`COMMIT_WIDTH-1:0]     commit_o;
    logic                            flush_o;
    flush_t                          flush_info_o;
    logic                            rob_empty_o;

    // model state
    preg_t    spec_m [`NUM_AREG];
    preg_t    arch_m [`NUM_AREG];
    preg_t    fl_q [$];
    rec_t     rec_q [$];
    rob_idx_t tail_m;

    logic [31:0] rng = 32'h70a561c6;
    pc_t   pc_ctr = 32'h1000;
    string cur_test = "reset";
    int    err_cnt, test_err_start, tests_run, tests_failed;
    int    dispatched, retired, dropped, flushes;
    bit    disp_en, wb_en, same_areg;
    int    exc_pct;

    rename_retire_top i_dut (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected retire record for one model entry
    function automatic commit_t ref_commit(input rec_t r);
        commit_t c;
        c.pc       = r.pc;
        c.areg     = r.areg;
        c.preg     = r.preg;
        c.opreg    = r.opreg;
        c.is_store = (r.fu == FU_STORE);
        return c;
    endfunction

    // old mapping of a slot, slot 0's new preg forwards to slot 1
    function automatic preg_t ref_opreg(input int slot);
        if (slot == 1 && dispatch_i[1].areg == dispatch_i[0].areg) begin
            return fl_q[0];
        end
        return spec_m[dispatch_i[slot].areg];
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    // ========================================================================
    // stimulus, driven 1 ns after the rising edge
    // ========================================================================

    task automatic drive_inputs();
        int n;
        int cand [$];
        int pick;
        dispatch_valid_i = '0;
        wb_valid_i       = '0;
        wb_i             = '0;
        if (disp_en) begin
            n = xorshift() % 3;
            dispatch_valid_i = (n == 2) ? 2'b11 : (n == 1) ? 2'b01 : 2'b00;
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                dispatch_i[i].pc   = pc_ctr;
                dispatch_i[i].fu   = fu_e'(xorshift() % 5);
                dispatch_i[i].areg = areg_t'(xorshift());
                pc_ctr = pc_ctr + 32'd4;
            end
            if (same_areg) begin
                dispatch_i[1].areg = dispatch_i[0].areg;
            end
        end
        // no writebacks while the buffer is being flushed
        if (!wb_en || flush_o) begin
            return;
        end
        for (int k = 0; k < `WB_WIDTH; k++) begin
            cand.delete();
            for (int j = 0; j < rec_q.size(); j++) begin
                if (!rec_q[j].sent) begin
                    cand.push_back(j);
                end
            end
            if (cand.size() > 0 && xorshift() % 2 == 0) begin
                pick = cand[xorshift() % cand.size()];
                rec_q[pick].sent    = 1'b1;
                wb_valid_i[k]       = 1'b1;
                wb_i[k].idx         = rec_q[pick].idx;
                wb_i[k].exception   = (xorshift() % 100) < exc_pct;
                wb_i[k].cause       = 5'(xorshift());
            end
        end
    endtask

    always @(posedge clk_i) begin
        #1;
        if (rst_ni) begin
            drive_inputs();
        end
    end

    // ========================================================================
    // compare process, outputs are stable at the falling edge
    // ========================================================================

    task automatic compare_cycle();
        bit    stop;
        bit    exp_flush;
        bit    exp_valid;
        bit    exp_ready;
        int    n_ret;
        rec_t  r;
        stop      = 0;
        exp_flush = 0;
        n_ret     = 0;
        exp_ready = (rec_q.size() <= `ROB_DEPTH - `DISPATCH_WIDTH) && (fl_q.size() >= 2);
        check_val("rob_empty", rec_q.size() == 0, rob_empty_o);
        check_val("dispatch_ready", exp_ready, dispatch_ready_o);
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            exp_valid = 0;
            if (!stop && i < rec_q.size()) begin
                if (!rec_q[i].done) begin
                    stop = 1;
                end else if (rec_q[i].exc) begin
                    stop      = 1;
                    exp_flush = 1;
                    check_val("flush pc", rec_q[i].pc, flush_info_o.pc);
                    check_val("flush cause", rec_q[i].cause, flush_info_o.cause);
                end else begin
                    exp_valid = 1;
                    n_ret++;
                    check_val("commit record", ref_commit(rec_q[i]), commit_o[i]);
                end
            end
            check_val("commit_valid", exp_valid, commit_valid_o[i]);
            if (commit_valid_o[i] === 1'b1) begin
                retired++;
            end
        end
        check_val("flush", exp_flush, flush_o);
        if (exp_ready && !exp_flush) begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (dispatch_valid_i[i]) begin
                    check_val("dispatch preg", fl_q[i], dispatch_preg_o[i]);
                    check_val("dispatch opreg", ref_opreg(i), dispatch_opreg_o[i]);
                    check_val("dispatch index", rob_idx_t'(tail_m + i), dispatch_index_o[i]);
                end
            end
        end
        // apply the edge to the model, retires first
        for (int i = 0; i < n_ret; i++) begin
            r = rec_q.pop_front();
            arch_m[r.areg] = r.preg;
            fl_q.push_back(r.opreg);
        end
        for (int k = 0; k < `WB_WIDTH; k++) begin
            for (int j = 0; j < rec_q.size(); j++) begin
                if (wb_valid_i[k] && rec_q[j].idx == wb_i[k].idx) begin
                    rec_q[j].done  = 1'b1;
                    rec_q[j].exc   = wb_i[k].exception;
                    rec_q[j].cause = wb_i[k].cause;
                end
            end
        end
        if (exp_flush) begin
            // unretired pregs go back ahead of the free ones, oldest first
            dropped += rec_q.size();
            for (int j = rec_q.size() - 1; j >= 0; j--) begin
                fl_q.push_front(rec_q[j].preg);
            end
            rec_q.delete();
            spec_m = arch_m;
            tail_m = '0;
            flushes++;
        end else if (exp_ready) begin
            // slots renamed in order, so slot 1 sees slot 0's mapping
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (dispatch_valid_i[i]) begin
                    r = '{dispatch_i[i].pc, dispatch_i[i].areg, dispatch_i[i].fu,
                          fl_q[0], spec_m[dispatch_i[i].areg], tail_m,
                          1'b0, 1'b0, 1'b0, 5'd0};
                    void'(fl_q.pop_front());
                    spec_m[r.areg] = r.preg;
                    rec_q.push_back(r);
                    tail_m = tail_m + 1'b1;
                    dispatched++;
                end
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_ni) begin
            compare_cycle();
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_cnt != test_err_start) begin
            tests_failed++;
        end
        $display("%-16s %s", cur_test, (err_cnt == test_err_start) ? "ok" : "errors");
    endtask

    task automatic abort_run(input string why);
        $display("timeout in %s: %s", cur_test, why);
        $display("test failed");
        $finish;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic drain();
        int t;
        disp_en = 0;
        wb_en   = 1;
        t       = 0;
        run_cycles(2);
        while (!(rob_empty_o && rec_q.size() == 0)) begin
            @(posedge clk_i);
            t++;
            if (t > 300) begin
                abort_run("buffer did not drain");
            end
        end
    endtask

    initial begin
        int t;
        for (int k = 0; k < `NUM_AREG; k++) begin
            spec_m[k] = preg_t'(k);
            arch_m[k] = preg_t'(k);
        end
        for (int k = `NUM_AREG; k < `NUM_PREG; k++) begin
            fl_q.push_back(preg_t'(k));
        end
        tail_m = '0;
        run_cycles(2);
        #1 rst_ni = 1'b1;

        start_test("reset_state");
        @(negedge clk_i);
        check_val("ready after reset", 1, dispatch_ready_o);
        check_val("empty after reset", 1, rob_empty_o);
        check_val("no retire after reset", 0, {commit_valid_o, flush_o});
        end_test();

        start_test("in_order_retire");
        disp_en = 1;
        wb_en   = 1;
        run_cycles(40);
        drain();
        end_test();

        start_test("rename_rules");
        same_areg = 1;
        disp_en   = 1;
        wb_en     = 1;
        run_cycles(60);
        same_areg = 0;
        drain();
        end_test();

        start_test("backpressure");
        disp_en = 1;
        wb_en   = 0;
        t       = 0;
        while (dispatch_ready_o) begin
            @(posedge clk_i);
            t++;
            if (t > 40) begin
                abort_run("ready never dropped");
            end
        end
        run_cycles(4);
        check_val("ready held low", 0, dispatch_ready_o);
        wb_en = 1;
        t     = 0;
        while (!dispatch_ready_o) begin
            @(posedge clk_i);
            t++;
            if (t > 60) begin
                abort_run("ready never came back");
            end
        end
        drain();
        end_test();

        start_test("exception_flush");
        exc_pct = 20;
        disp_en = 1;
        wb_en   = 1;
        t       = 0;
        while (flushes < 3) begin
            @(posedge clk_i);
            t++;
            if (t > 400) begin
                abort_run("no flush raised");
            end
        end
        run_cycles(20);
        exc_pct = 0;
        drain();
        end_test();

        start_test("long_random");
        exc_pct = 2;
        disp_en = 1;
        wb_en   = 1;
        run_cycles(1500);
        exc_pct = 0;
        drain();
        check_val("retired exactly once", dispatched, retired + dropped);
        end_test();

        $display("tests %0d, failed %0d, errors %0d, retired %0d, flushes %0d",
                 tests_run, tests_failed, err_cnt, retired, flushes);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: rtl/rename_retire_top.sv
// no handshake on writeback or retire; dispatch slots must be packed from slot 0
`include "rob_params.svh"

module rename_retire_top import rob_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic [`DISPATCH_WIDTH-1:0]      dispatch_valid_i,
    input  dispatch_t [`DISPATCH_WIDTH-1:0] dispatch_i,
    output logic                            dispatch_ready_o,
    output rob_idx_t [`DISPATCH_WIDTH-1:0]  dispatch_index_o,
    output preg_t [`DISPATCH_WIDTH-1:0]     dispatch_preg_o,
    output preg_t [`DISPATCH_WIDTH-1:0]     dispatch_opreg_o,

    input  logic [`WB_WIDTH-1:0]            wb_valid_i,
    input  wb_t [`WB_WIDTH-1:0]             wb_i,

    output logic [`COMMIT_WIDTH-1:0]        commit_valid_o,
    output commit_t [`COMMIT_WIDTH-1:0]     commit_o,
    output logic                            flush_o,
    output flush_t                          flush_info_o,
    output logic                            rob_empty_o
);

    logic                        rob_ready;
    logic                        alloc_ready;
    logic [`DISPATCH_WIDTH-1:0]  accept;

    // ready only with room in both the buffer and the free list
    assign dispatch_ready_o = rob_ready & alloc_ready;
    assign accept           = dispatch_valid_i & {`DISPATCH_WIDTH{dispatch_ready_o}};

    reorder_buffer i_reorder_buffer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .accept_i       (accept),
        .dispatch_i     (dispatch_i),
        .preg_i         (dispatch_preg_o),
        .opreg_i        (dispatch_opreg_o),
        .rob_ready_o    (rob_ready),
        .index_o        (dispatch_index_o),
        .wb_valid_i     (wb_valid_i),
        .wb_i           (wb_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .flush_o        (flush_o),
        .flush_info_o   (flush_info_o),
        .rob_empty_o    (rob_empty_o)
    );

    free_list i_free_list (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .accept_i       (accept),
        .preg_o         (dispatch_preg_o),
        .alloc_ready_o  (alloc_ready),
        .commit_valid_i (commit_valid_o),
        .commit_i       (commit_o),
        .flush_i        (flush_o)
    );

    rename_map i_rename_map (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .accept_i       (accept),
        .dispatch_i     (dispatch_i),
        .preg_i         (dispatch_preg_o),
        .opreg_o        (dispatch_opreg_o),
        .commit_valid_i (commit_valid_o),
        .commit_i       (commit_o),
        .flush_i        (flush_o)
    );

endmodule

// File: rtl/rename_map.sv
// renames destinations only; slot order within a group is program order
`include "rob_params.svh"

module rename_map import rob_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic [`DISPATCH_WIDTH-1:0]      accept_i,
    input  dispatch_t [`DISPATCH_WIDTH-1:0] dispatch_i,
    input  preg_t [`DISPATCH_WIDTH-1:0]     preg_i,
    output preg_t [`DISPATCH_WIDTH-1:0]     opreg_o,

    input  logic [`COMMIT_WIDTH-1:0]        commit_valid_i,
    input  commit_t [`COMMIT_WIDTH-1:0]     commit_i,
    input  logic                            flush_i
);

    preg_t spec_q [`NUM_AREG];
    preg_t arch_q [`NUM_AREG];
    preg_t arch_d [`NUM_AREG];

    // old mapping, an older slot of the same group overrides the table
    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            opreg_o[i] = spec_q[dispatch_i[i].areg];
            for (int j = 0; j < i; j++) begin
                if (accept_i[j] && (dispatch_i[j].areg == dispatch_i[i].areg)) begin
                    opreg_o[i] = preg_i[j];
                end
            end
        end
    end

    // retire slots applied oldest first
    always_comb begin
        arch_d = arch_q;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (commit_valid_i[i]) begin
                arch_d[commit_i[i].areg] = commit_i[i].preg;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int k = 0; k < `NUM_AREG; k++) begin
                spec_q[k] <= preg_t'(k);
                arch_q[k] <= preg_t'(k);
            end
        end else begin
            arch_q <= arch_d;
            if (flush_i) begin
                // rebuild from the committed state including this cycle's retires
                spec_q <= arch_d;
            end else begin
                // later slot wins on a shared areg
                for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                    if (accept_i[i]) begin
                        spec_q[dispatch_i[i].areg] <= preg_i[i];
                    end
                end
            end
        end
    end

endmodule

// File: rtl/free_list.sv
// ring assumes every retire frees exactly one opreg; alloc_ready is the only overflow guard
`include "rob_params.svh"

module free_list import rob_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic [`DISPATCH_WIDTH-1:0]      accept_i,
    output preg_t [`DISPATCH_WIDTH-1:0]     preg_o,
    output logic                            alloc_ready_o,

    input  logic [`COMMIT_WIDTH-1:0]        commit_valid_i,
    input  commit_t [`COMMIT_WIDTH-1:0]     commit_i,
    input  logic                            flush_i
);

    typedef logic [`FL_PTR_W-1:0] fl_ptr_t;
    typedef logic [`FL_PTR_W:0]   fl_cnt_t;

    preg_t   fifo_q [`FL_DEPTH];
    fl_ptr_t alloc_ptr_q;
    fl_ptr_t rel_ptr_q;
    fl_ptr_t cmt_ptr_q;
    fl_ptr_t cmt_ptr_d;
    fl_cnt_t count_q;
    logic [1:0] n_acc;
    logic [1:0] n_ret;

    // advance a pointer around a ring that is not a power of two
    function automatic fl_ptr_t fl_wrap(input fl_ptr_t ptr, input logic [1:0] step);
        logic [`FL_PTR_W:0] sum;
        sum = ptr + step;
        if (sum >= `FL_DEPTH) begin
            sum = sum - `FL_DEPTH;
        end
        return sum[`FL_PTR_W-1:0];
    endfunction

    always_comb begin
        n_acc = '0;
        n_ret = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            preg_o[i] = fifo_q[fl_wrap(alloc_ptr_q, i[1:0])];
            if (accept_i[i]) begin
                n_acc = n_acc + 2'd1;
            end
        end
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (commit_valid_i[i]) begin
                n_ret = n_ret + 2'd1;
            end
        end
    end

    assign alloc_ready_o = (count_q >= `DISPATCH_WIDTH);
    assign cmt_ptr_d     = fl_wrap(cmt_ptr_q, n_ret);

    // slots between commit and alloc are in flight; flush hands them back
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int k = 0; k < `FL_DEPTH; k++) begin
                fifo_q[k] <= preg_t'(k + `NUM_AREG);
            end
            alloc_ptr_q <= '0;
            rel_ptr_q   <= '0;
            cmt_ptr_q   <= '0;
            count_q     <= fl_cnt_t'(`FL_DEPTH);
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (commit_valid_i[i]) begin
                    fifo_q[fl_wrap(rel_ptr_q, i[1:0])] <= commit_i[i].opreg;
                end
            end
            rel_ptr_q <= fl_wrap(rel_ptr_q, n_ret);
            cmt_ptr_q <= cmt_ptr_d;
            if (flush_i) begin
                alloc_ptr_q <= cmt_ptr_d;
                count_q     <= fl_cnt_t'(`FL_DEPTH);
            end else begin
                alloc_ptr_q <= fl_wrap(alloc_ptr_q, n_acc);
                count_q     <= count_q + n_ret - n_acc;
            end
        end
    end

endmodule

// File: rtl/reorder_buffer.sv
// accept must be packed from slot 0 and already include ready; writebacks must hit live entries
`include "rob_params.svh"

module reorder_buffer import rob_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // dispatch side
    input  logic [`DISPATCH_WIDTH-1:0]          accept_i,
    input  dispatch_t [`DISPATCH_WIDTH-1:0]     dispatch_i,
    input  preg_t [`DISPATCH_WIDTH-1:0]         preg_i,
    input  preg_t [`DISPATCH_WIDTH-1:0]         opreg_i,
    output logic                                rob_ready_o,
    output rob_idx_t [`DISPATCH_WIDTH-1:0]      index_o,

    // completion
    input  logic [`WB_WIDTH-1:0]                wb_valid_i,
    input  wb_t [`WB_WIDTH-1:0]                 wb_i,

    // retire and flush
    output logic [`COMMIT_WIDTH-1:0]            commit_valid_o,
    output commit_t [`COMMIT_WIDTH-1:0]         commit_o,
    output logic                                flush_o,
    output flush_t                              flush_info_o,
    output logic                                rob_empty_o
);

    rob_entry_t rob_q [`ROB_DEPTH];

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [`ROB_IDX_W:0]  count_q;

    rob_idx_t             rd_idx [`COMMIT_WIDTH];
    rob_entry_t           new_entry [`DISPATCH_WIDTH];
    logic [1:0]           n_acc;
    logic [1:0]           n_ret;
    logic                 stop;

    // keep room for a full group
    assign rob_ready_o = (count_q <= (`ROB_DEPTH - `DISPATCH_WIDTH));
    assign rob_empty_o = (count_q == '0);

    // ========================================================================
    // dispatch
    // ========================================================================

    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            index_o[i]             = tail_q + rob_idx_t'(i);
            new_entry[i].complete  = 1'b0;
            new_entry[i].exception = 1'b0;
            new_entry[i].cause     = '0;
            new_entry[i].fu        = dispatch_i[i].fu;
            new_entry[i].areg      = dispatch_i[i].areg;
            new_entry[i].preg      = preg_i[i];
            new_entry[i].opreg     = opreg_i[i];
            new_entry[i].pc        = dispatch_i[i].pc;
        end
    end

    always_comb begin
        n_acc = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (accept_i[i]) begin
                n_acc = n_acc + 2'd1;
            end
        end
    end

    // ========================================================================
    // retire window
    // ========================================================================

    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            rd_idx[i] = head_q + rob_idx_t'(i);
        end
    end

    // scan from the head, first incomplete or faulting entry ends the window
    always_comb begin
        stop         = 1'b0;
        flush_o      = 1'b0;
        flush_info_o = '0;
        n_ret        = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commit_valid_o[i]    = 1'b0;
            commit_o[i].pc       = rob_q[rd_idx[i]].pc;
            commit_o[i].areg     = rob_q[rd_idx[i]].areg;
            commit_o[i].preg     = rob_q[rd_idx[i]].preg;
            commit_o[i].opreg    = rob_q[rd_idx[i]].opreg;
            commit_o[i].is_store = (rob_q[rd_idx[i]].fu == FU_STORE);
            if ((count_q > i) && !stop) begin
                if (!rob_q[rd_idx[i]].complete) begin
                    stop = 1'b1;
                end else if (rob_q[rd_idx[i]].exception) begin
                    stop               = 1'b1;
                    flush_o            = 1'b1;
                    flush_info_o.pc    = rob_q[rd_idx[i]].pc;
                    flush_info_o.cause = rob_q[rd_idx[i]].cause;
                end else begin
                    commit_valid_o[i] = 1'b1;
                    n_ret             = n_ret + 2'd1;
                end
            end
        end
    end

    // ========================================================================
    // state
    // ========================================================================

    // entries past count are dead, so a write in the flush cycle is harmless
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (accept_i[i]) begin
                rob_q[index_o[i]] <= new_entry[i];
            end
        end
        for (int k = 0; k < `WB_WIDTH; k++) begin
            if (wb_valid_i[k]) begin
                rob_q[wb_i[k].idx].complete  <= 1'b1;
                rob_q[wb_i[k].idx].exception <= wb_i[k].exception;
                rob_q[wb_i[k].idx].cause     <= wb_i[k].cause;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_o) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + n_ret;
            tail_q  <= tail_q + n_acc;
            count_q <= count_q + n_acc - n_ret;
        end
    end

endmodule

// File: rtl/rob_pkg.sv
// shared types only; field widths come from the params header and are not checked here
`include "rob_params.svh"

package rob_pkg;

    typedef logic [`PLEN-1:0]      pc_t;
    typedef logic [`AREG_W-1:0]    areg_t;
    typedef logic [`PREG_W-1:0]    preg_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // functional unit kind, stores allocate a dest like everything else
    typedef enum logic [2:0] {
        FU_ALU,
        FU_MUL,
        FU_LOAD,
        FU_STORE,
        FU_BRANCH
    } fu_e;

    typedef struct packed {
        pc_t   pc;
        fu_e   fu;
        areg_t areg;
    } dispatch_t;

    typedef struct packed {
        rob_idx_t   idx;
        logic       exception;
        logic [4:0] cause;
    } wb_t;

    typedef struct packed {
        logic       complete;
        logic       exception;
        logic [4:0] cause;
        fu_e        fu;
        areg_t      areg;
        preg_t      preg;
        preg_t      opreg;
        pc_t        pc;
    } rob_entry_t;

    typedef struct packed {
        pc_t   pc;
        areg_t areg;
        preg_t preg;
        preg_t opreg;
        logic  is_store;
    } commit_t;

    typedef struct packed {
        pc_t        pc;
        logic [4:0] cause;
    } flush_t;

endpackage

// File: rtl/rob_params.svh
// fixed two-wide machine; the index widths below must track the depths by hand
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer and pipeline widths
`define ROB_DEPTH       16
`define DISPATCH_WIDTH  2
`define COMMIT_WIDTH    2
`define WB_WIDTH        2

// register files
`define NUM_AREG        8
`define NUM_PREG        32
`define PLEN            32

// derived index widths
`define ROB_IDX_W       4
`define AREG_W          3
`define PREG_W          5

// free list holds every preg not mapped at reset
`define FL_DEPTH        24
`define FL_PTR_W        5

`endif
